//--- cache_pkg.sv
`default_nettype none

package cache_pkg;

	// Data words and byte addresses share one width.
	localparam int word_w = 16;

	// Address split into tag, line index and byte offset within the line.
	localparam int tag_w    = 5;
	localparam int index_w  = 8;
	localparam int offset_w = 3;

	// Direct-mapped geometry.
	localparam int lines          = 256;
	localparam int words_per_line = 4;

	// Cycles from a read strobe to valid read data.
	localparam int mem_rd_latency = 2;

	// Power-up memory content is the byte address XOR this key.
	localparam logic [word_w-1:0] mem_init_key = 16'h5a5a;

	// Controller states.
	typedef enum logic [3:0] {
		st_idle,
		st_cmp_rd,
		st_cmp_wr,
		st_evict0,
		st_evict1,
		st_evict2,
		st_evict3,
		st_alloc0,
		st_alloc1,
		st_alloc2,
		st_alloc3,
		st_aw0,
		st_aw1
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- cache_array.sv
`default_nettype none

module cache_array (
	input wire clk,
	input wire rst,
	input wire en,
	input wire cmp,
	input wire write,
	input wire valid_in,
	input wire [cache_pkg::tag_w-1:0] tag_in,
	input wire [cache_pkg::index_w-1:0] index,
	input wire [cache_pkg::offset_w-1:0] offset_in,
	input wire [cache_pkg::word_w-1:0] cache_data_in,
	output logic hit,
	output logic dirty,
	output logic valid,
	output logic [cache_pkg::tag_w-1:0] tag_out,
	output logic [cache_pkg::word_w-1:0] data_out
);

	logic [cache_pkg::tag_w-1:0] tag_mem [cache_pkg::lines];
	logic [cache_pkg::word_w-1:0] word_mem [cache_pkg::lines][cache_pkg::words_per_line];
	logic [cache_pkg::lines-1:0] valid_bits;
	logic [cache_pkg::lines-1:0] dirty_bits;

	logic [cache_pkg::offset_w-2:0] word_sel;
	logic fill_wr;
	logic hit_wr;

	// Byte offset to word within the line.
	assign word_sel = offset_in[cache_pkg::offset_w-1:1];

	assign valid    = valid_bits[index];
	assign dirty    = dirty_bits[index];
	assign tag_out  = tag_mem[index];
	assign data_out = word_mem[index][word_sel];

	assign hit = cmp && valid && (tag_out == tag_in);

	// Fill installs the tag; a compare-write only touches a line that hits.
	assign fill_wr = en && write && !cmp;
	assign hit_wr  = en && write && cmp && hit;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (fill_wr) begin
			valid_bits[index] <= valid_in;
			dirty_bits[index] <= 1'b0;
		end else if (hit_wr) begin
			dirty_bits[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_wr)
			tag_mem[index] <= tag_in;
		if (fill_wr || hit_wr)
			word_mem[index][word_sel] <= cache_data_in;
	end

endmodule

`default_nettype wire

//--- main_mem.sv
`default_nettype none

module main_mem (
	input wire clk,
	input wire rst,
	input wire wr,
	input wire rd,
	input wire [cache_pkg::word_w-1:0] mem_addr,
	input wire [cache_pkg::word_w-1:0] mem_data_out,
	output logic [cache_pkg::word_w-1:0] data_mem
);

	logic [cache_pkg::word_w-1:0] mem [2**(cache_pkg::word_w-1)];
	logic [cache_pkg::word_w-1:0] rd_pipe [cache_pkg::mem_rd_latency];
	logic [cache_pkg::word_w-2:0] word_addr;

	// Word address with the byte bit dropped.
	assign word_addr = mem_addr[cache_pkg::word_w-1:1];

	initial begin
		for (int i = 0; i < 2**(cache_pkg::word_w-1); i++)
			mem[i] = cache_pkg::word_w'(i << 1) ^ cache_pkg::mem_init_key;
	end

	always @(posedge clk) begin
		if (wr)
			mem[word_addr] <= mem_data_out;
	end

	// Each stage can hold its own read, so back-to-back reads overlap.
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < cache_pkg::mem_rd_latency; s++)
				rd_pipe[s] <= '0;
		end else begin
			if (rd)
				rd_pipe[0] <= mem[word_addr];
			for (int s = 1; s < cache_pkg::mem_rd_latency; s++)
				rd_pipe[s] <= rd_pipe[s-1];
		end
	end

	assign data_mem = rd_pipe[cache_pkg::mem_rd_latency-1];

endmodule

`default_nettype wire

//--- cache_ctrl.sv
`default_nettype none

module cache_ctrl (
	input wire clk,
	input wire rst,
	input wire ld,
	input wire st,
	input wire [cache_pkg::word_w-1:0] address,
	input wire [cache_pkg::word_w-1:0] data_sys,
	input wire hit,
	input wire dirty,
	input wire valid,
	input wire [cache_pkg::tag_w-1:0] tag_out,
	input wire [cache_pkg::word_w-1:0] data_out,
	input wire [cache_pkg::word_w-1:0] data_mem,
	output logic en,
	output logic cmp,
	output logic write,
	output logic valid_in,
	output logic [cache_pkg::tag_w-1:0] tag_in,
	output logic [cache_pkg::index_w-1:0] index,
	output logic [cache_pkg::offset_w-1:0] offset_in,
	output logic [cache_pkg::word_w-1:0] cache_data_in,
	output logic wr,
	output logic rd,
	output logic [cache_pkg::word_w-1:0] mem_addr,
	output logic [cache_pkg::word_w-1:0] mem_data_out,
	output logic [cache_pkg::word_w-1:0] data_out_sys,
	output logic done,
	output logic cache_hit,
	output logic stall
);

	cache_pkg::ctrl_state_t state, nxt_state;

	// Request captured at the strobe.
	logic req_st;
	logic [cache_pkg::word_w-1:0] req_addr;
	logic [cache_pkg::word_w-1:0] req_data;
	logic [cache_pkg::tag_w-1:0] victim_tag;

	logic [cache_pkg::tag_w-1:0] req_tag;
	logic [cache_pkg::index_w-1:0] req_index;
	logic [cache_pkg::offset_w-2:0] req_word;

	logic evicting;
	logic reading;
	logic filling;
	logic [cache_pkg::offset_w-2:0] ev_word;
	logic [cache_pkg::offset_w-2:0] rd_word;
	logic [cache_pkg::offset_w-2:0] fill_word;

	logic accept;
	logic [cache_pkg::word_w-1:0] data_now;
	logic [cache_pkg::word_w-1:0] data_hold;

	assign req_tag   = req_addr[cache_pkg::word_w-1 -: cache_pkg::tag_w];
	assign req_index = req_addr[cache_pkg::offset_w +: cache_pkg::index_w];
	assign req_word  = req_addr[cache_pkg::offset_w-1:1];

	assign accept = (state == cache_pkg::st_idle) && (ld || st);
	assign stall  = (state != cache_pkg::st_idle);

	always_comb begin
		nxt_state = state;
		case (state)
			cache_pkg::st_idle: begin
				if (ld)
					nxt_state = cache_pkg::st_cmp_rd;
				else if (st)
					nxt_state = cache_pkg::st_cmp_wr;
			end
			cache_pkg::st_cmp_rd, cache_pkg::st_cmp_wr: begin
				if (hit)
					nxt_state = cache_pkg::st_idle;
				else if (valid && dirty)
					nxt_state = cache_pkg::st_evict0;
				else
					nxt_state = cache_pkg::st_alloc0;
			end
			cache_pkg::st_evict0: nxt_state = cache_pkg::st_evict1;
			cache_pkg::st_evict1: nxt_state = cache_pkg::st_evict2;
			cache_pkg::st_evict2: nxt_state = cache_pkg::st_evict3;
			cache_pkg::st_evict3: nxt_state = cache_pkg::st_alloc0;
			cache_pkg::st_alloc0: nxt_state = cache_pkg::st_alloc1;
			cache_pkg::st_alloc1: nxt_state = cache_pkg::st_alloc2;
			cache_pkg::st_alloc2: nxt_state = cache_pkg::st_alloc3;
			cache_pkg::st_alloc3: nxt_state = cache_pkg::st_aw0;
			cache_pkg::st_aw0: nxt_state = cache_pkg::st_aw1;
			default: nxt_state = cache_pkg::st_idle;
		endcase
	end

	// Reads run two states ahead of the fill that consumes them.
	always_comb begin
		evicting  = 1'b0;
		reading   = 1'b0;
		filling   = 1'b0;
		ev_word   = 2'd0;
		rd_word   = 2'd0;
		fill_word = 2'd0;
		case (state)
			cache_pkg::st_evict0: evicting = 1'b1;
			cache_pkg::st_evict1: begin
				evicting = 1'b1;
				ev_word  = 2'd1;
			end
			cache_pkg::st_evict2: begin
				evicting = 1'b1;
				ev_word  = 2'd2;
			end
			cache_pkg::st_evict3: begin
				evicting = 1'b1;
				ev_word  = 2'd3;
			end
			cache_pkg::st_alloc0: reading = 1'b1;
			cache_pkg::st_alloc1: begin
				reading = 1'b1;
				rd_word = 2'd1;
			end
			cache_pkg::st_alloc2: begin
				reading = 1'b1;
				rd_word = 2'd2;
				filling = 1'b1;
			end
			cache_pkg::st_alloc3: begin
				reading   = 1'b1;
				rd_word   = 2'd3;
				filling   = 1'b1;
				fill_word = 2'd1;
			end
			cache_pkg::st_aw0: begin
				filling   = 1'b1;
				fill_word = 2'd2;
			end
			cache_pkg::st_aw1: begin
				filling   = 1'b1;
				fill_word = 2'd3;
			end
			default: ;
		endcase
	end

	always_comb begin
		en            = 1'b0;
		cmp           = 1'b0;
		write         = 1'b0;
		valid_in      = 1'b0;
		tag_in        = req_tag;
		index         = req_index;
		offset_in     = req_addr[cache_pkg::offset_w-1:0];
		cache_data_in = req_data;
		wr            = 1'b0;
		rd            = reading;
		mem_addr      = {req_tag, req_index, rd_word, 1'b0};
		mem_data_out  = data_out;
		done          = 1'b0;
		cache_hit     = 1'b0;

		// Idle looks up the incoming address so the victim tag is ready at the strobe.
		if (state == cache_pkg::st_idle) begin
			tag_in    = address[cache_pkg::word_w-1 -: cache_pkg::tag_w];
			index     = address[cache_pkg::offset_w +: cache_pkg::index_w];
			offset_in = address[cache_pkg::offset_w-1:0];
		end

		if (state == cache_pkg::st_cmp_rd || state == cache_pkg::st_cmp_wr) begin
			en        = 1'b1;
			cmp       = 1'b1;
			write     = (state == cache_pkg::st_cmp_wr);
			valid_in  = 1'b1;
			done      = hit;
			cache_hit = hit;
		end

		if (evicting) begin
			en        = 1'b1;
			offset_in = {ev_word, 1'b0};
			wr        = 1'b1;
			mem_addr  = {victim_tag, req_index, ev_word, 1'b0};
		end

		if (filling) begin
			en        = 1'b1;
			write     = 1'b1;
			valid_in  = 1'b1;
			offset_in = {fill_word, 1'b0};
			// Last fill of a store doubles as a compare-write to mark the line dirty.
			cmp       = req_st && (state == cache_pkg::st_aw1);
			if (!(req_st && fill_word == req_word))
				cache_data_in = data_mem;
			done = (fill_word == req_word);
		end
	end

	assign data_now     = filling ? cache_data_in : (req_st ? req_data : data_out);
	assign data_out_sys = done ? data_now : data_hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= cache_pkg::st_idle;
			req_st <= 1'b0;
		end else begin
			state <= nxt_state;
			if (accept)
				req_st <= !ld;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_addr   <= address;
			req_data   <= data_sys;
			victim_tag <= tag_out;
		end
		if (done)
			data_hold <= data_now;
	end

endmodule

`default_nettype wire

//--- cache_top.sv
`default_nettype none

module cache_top (
	input wire clk,
	input wire rst,
	input wire ld,
	input wire st,
	input wire [cache_pkg::word_w-1:0] address,
	input wire [cache_pkg::word_w-1:0] data_sys,
	output logic [cache_pkg::word_w-1:0] data_out_sys,
	output logic done,
	output logic cache_hit,
	output logic stall
);

	// Controller to array.
	logic en;
	logic cmp;
	logic write;
	logic valid_in;
	logic [cache_pkg::tag_w-1:0] tag_in;
	logic [cache_pkg::index_w-1:0] index;
	logic [cache_pkg::offset_w-1:0] offset_in;
	logic [cache_pkg::word_w-1:0] cache_data_in;

	// Array to controller.
	logic hit;
	logic dirty;
	logic valid;
	logic [cache_pkg::tag_w-1:0] tag_out;
	logic [cache_pkg::word_w-1:0] data_out;

	// Controller and memory.
	logic wr;
	logic rd;
	logic [cache_pkg::word_w-1:0] mem_addr;
	logic [cache_pkg::word_w-1:0] mem_data_out;
	logic [cache_pkg::word_w-1:0] data_mem;

	cache_ctrl ctrl_i (
		.clk(clk), .rst(rst), .ld(ld), .st(st), .address(address), .data_sys(data_sys),
		.hit(hit), .dirty(dirty), .valid(valid), .tag_out(tag_out), .data_out(data_out),
		.data_mem(data_mem), .en(en), .cmp(cmp), .write(write), .valid_in(valid_in),
		.tag_in(tag_in), .index(index), .offset_in(offset_in), .cache_data_in(cache_data_in),
		.wr(wr), .rd(rd), .mem_addr(mem_addr), .mem_data_out(mem_data_out),
		.data_out_sys(data_out_sys), .done(done), .cache_hit(cache_hit), .stall(stall)
	);

	cache_array array_i (
		.clk(clk), .rst(rst), .en(en), .cmp(cmp), .write(write), .valid_in(valid_in),
		.tag_in(tag_in), .index(index), .offset_in(offset_in), .cache_data_in(cache_data_in),
		.hit(hit), .dirty(dirty), .valid(valid), .tag_out(tag_out), .data_out(data_out)
	);

	main_mem mem_i (
		.clk(clk), .rst(rst), .wr(wr), .rd(rd), .mem_addr(mem_addr),
		.mem_data_out(mem_data_out), .data_mem(data_mem)
	);

endmodule

`default_nettype wire

//--- cache_checker.sv
`default_nettype none

module cache_checker (
	input wire clk,
	input wire rst,
	input wire ld,
	input wire st,
	input wire [cache_pkg::word_w-1:0] address,
	input wire [cache_pkg::word_w-1:0] data_sys,
	input wire [cache_pkg::word_w-1:0] data_out_sys,
	input wire done,
	input wire cache_hit,
	input wire stall,
	input wire cache_pkg::ctrl_state_t ctrl_state,
	input wire [8*12-1:0] test_name,
	input wire [1:0] exp_hit,
	input wire [cache_pkg::word_w-1:0] exp_data,
	output int hit_errs,
	output int data_errs,
	output int proto_errs
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [cache_pkg::word_w-1:0] shadow [2**(cache_pkg::word_w-1)];
	logic [cache_pkg::tag_w-1:0] model_tag [cache_pkg::lines];
	logic [cache_pkg::lines-1:0] model_valid;
	logic [cache_pkg::lines-1:0] model_dirty;

	logic [4:0] a_tag;
	logic [7:0] a_idx;
	logic [14:0] a_word;

	// Access in flight.
	logic pending;
	logic req_ld;
	logic req_hit;
	logic [cache_pkg::word_w-1:0] req_data;
	logic [8*12-1:0] req_name;
	logic [1:0] req_exp_hit;
	logic [cache_pkg::word_w-1:0] req_exp_data;
	int req_lat;
	int lat;
	int stall_cycles;

	// Controller busy from the strobe until it is back in idle.
	logic busy;
	int busy_cycles;
	int exp_busy;

	assign a_tag  = address[15:11];
	assign a_idx  = address[10:3];
	assign a_word = address[15:1];

	initial begin
		hit_errs   = 0;
		data_errs  = 0;
		proto_errs = 0;
		for (int i = 0; i < 2**(cache_pkg::word_w-1); i++)
			shadow[i] = {i[14:0], 1'b0} ^ cache_pkg::mem_init_key;
	end

	task automatic accept_access();
		req_ld       = ld;
		req_hit      = model_valid[a_idx] && (model_tag[a_idx] == a_tag);
		req_data     = shadow[a_word];
		req_name     = test_name;
		req_exp_hit  = exp_hit;
		req_exp_data = exp_data;
		// A miss on a dirty line spends four cycles on the write-back first.
		if (req_hit) begin
			req_lat  = 1;
			exp_busy = 2;
		end else if (model_valid[a_idx] && model_dirty[a_idx]) begin
			req_lat  = 8 + int'(address[2:1]);
			exp_busy = 12;
		end else begin
			req_lat  = 4 + int'(address[2:1]);
			exp_busy = 8;
		end
		if (!req_hit)
			model_dirty[a_idx] = 1'b0;
		model_valid[a_idx] = 1'b1;
		model_tag[a_idx]   = a_tag;
		if (!ld) begin
			shadow[a_word]     = data_sys;
			model_dirty[a_idx] = 1'b1;
		end
		lat         = 0;
		pending     = 1'b1;
		busy_cycles = 0;
		busy        = 1'b1;
	endtask

	task automatic compare_result();
		if (cache_hit !== req_hit) begin
			$display("** Error %0s: hit (model) expected %0d actual %0d", req_name, req_hit,
				cache_hit);
			hit_errs++;
		end
		if (req_exp_hit != 2'd2 && cache_hit !== req_exp_hit[0]) begin
			$display("** Error %0s: hit (table) expected %0d actual %0d", req_name,
				req_exp_hit[0], cache_hit);
			hit_errs++;
		end
		if (lat != req_lat) begin
			$display("** Error %0s: done cycle expected %0d actual %0d", req_name, req_lat, lat);
			proto_errs++;
		end
		if (req_ld && data_out_sys !== req_data) begin
			$display("** Error %0s: load data (model) expected %h actual %h", req_name, req_data,
				data_out_sys);
			data_errs++;
		end
		// Table data is only given where the table also fixes the hit.
		if (req_ld && req_exp_hit != 2'd2 && data_out_sys !== req_exp_data) begin
			$display("** Error %0s: load data (table) expected %h actual %h", req_name,
				req_exp_data, data_out_sys);
			data_errs++;
		end
	endtask

	always @(posedge clk) begin
		if (rst) begin
			pending      = 1'b0;
			busy         = 1'b0;
			model_valid  = '0;
			model_dirty  = '0;
			stall_cycles = 0;
		end else begin
			if (pending)
				lat++;
			if (done) begin
				if (pending)
					compare_result();
				else begin
					$display("Done pulsed while no access was outstanding");
					proto_errs++;
				end
				pending = 1'b0;
			end else if (pending && !stall) begin
				$display("%0s: controller went idle without a done pulse", req_name);
				proto_errs++;
				pending = 1'b0;
			end
			if (busy) begin
				busy_cycles++;
				if (!stall) begin
					if (busy_cycles != exp_busy) begin
						$display("** Error %0s: stall cycles expected %0d actual %0d", req_name,
							exp_busy, busy_cycles);
						proto_errs++;
					end
					busy = 1'b0;
				end
			end
			stall_cycles = stall ? stall_cycles + 1 : 0;
			if (stall_cycles == 13) begin
				$display("%0s: stall stayed high for more than 12 cycles in state %s", req_name,
					ctrl_state.name());
				proto_errs++;
			end
			if (!stall && (ld || st))
				accept_access();
		end
	end

endmodule

`default_nettype wire

//--- tb_cache.sv
`default_nettype none

module tb_cache;

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic [8*12-1:0] name;
		logic is_st;
		logic [cache_pkg::word_w-1:0] addr;
		logic [cache_pkg::word_w-1:0] data;
		logic [1:0] hit;
		logic [cache_pkg::word_w-1:0] rdata;
	} entry_t;

	logic clk;
	logic rst;
	logic ld;
	logic st;
	logic [cache_pkg::word_w-1:0] address;
	logic [cache_pkg::word_w-1:0] data_sys;
	logic [cache_pkg::word_w-1:0] data_out_sys;
	logic done;
	logic cache_hit;
	logic stall;

	// Expectation of the entry in flight, seen by the checker.
	// Hit is 0 or 1, and 2 where the table leaves it open.
	logic [8*12-1:0] cur_name;
	logic [1:0] cur_hit;
	logic [cache_pkg::word_w-1:0] cur_data;

	int hit_errs;
	int data_errs;
	int proto_errs;
	integer seed;
	entry_t stim[$];

	cache_top cache_top_i (
		.clk(clk), .rst(rst), .ld(ld), .st(st), .address(address), .data_sys(data_sys),
		.data_out_sys(data_out_sys), .done(done), .cache_hit(cache_hit), .stall(stall)
	);

	cache_checker check_i (
		.clk(clk), .rst(rst), .ld(ld), .st(st), .address(address), .data_sys(data_sys),
		.data_out_sys(data_out_sys), .done(done), .cache_hit(cache_hit), .stall(stall),
		.ctrl_state(cache_top_i.ctrl_i.state), .test_name(cur_name), .exp_hit(cur_hit),
		.exp_data(cur_data), .hit_errs(hit_errs), .data_errs(data_errs),
		.proto_errs(proto_errs)
	);

	always #50 clk = ~clk;

	function automatic logic [cache_pkg::word_w-1:0] word_addr(
		input logic [cache_pkg::tag_w-1:0] tag,
		input logic [cache_pkg::index_w-1:0] idx,
		input logic [1:0] word
	);
		return {tag, idx, word, 1'b0};
	endfunction

	// Power-up content of a memory word.
	function automatic logic [cache_pkg::word_w-1:0] mem_word(
		input logic [cache_pkg::word_w-1:0] a
	);
		return a ^ 16'h5a5a;
	endfunction

	function automatic void add_entry(input string name, input logic is_st,
			input logic [cache_pkg::word_w-1:0] addr, input logic [cache_pkg::word_w-1:0] data,
			input logic [1:0] hit, input logic [cache_pkg::word_w-1:0] rdata);
		entry_t e;
		$sformat(e.name, "%s", name);
		e.is_st = is_st;
		e.addr  = addr;
		e.data  = data;
		e.hit   = hit;
		e.rdata = rdata;
		stim.push_back(e);
	endfunction

	function automatic void build_table();
		logic [31:0] r;
		logic [cache_pkg::tag_w-1:0] tag;
		logic [cache_pkg::index_w-1:0] idx;
		int t;

		add_entry("cold_ld", 1'b0, word_addr(5'd3, 8'h10, 2'd1), '0, 2'd0,
			mem_word(word_addr(5'd3, 8'h10, 2'd1)));
		for (int w = 0; w < 4; w++) begin
			if (w != 1)
				add_entry($sformatf("hit_w%0d", w), 1'b0, word_addr(5'd3, 8'h10, w[1:0]), '0,
					2'd1, mem_word(word_addr(5'd3, 8'h10, w[1:0])));
		end
		add_entry("st_hit", 1'b1, word_addr(5'd3, 8'h10, 2'd2), 16'hbeef, 2'd1, '0);
		add_entry("ld_after_st", 1'b0, word_addr(5'd3, 8'h10, 2'd2), '0, 2'd1, 16'hbeef);
		add_entry("ld_evict", 1'b0, word_addr(5'd7, 8'h10, 2'd0), '0, 2'd0,
			mem_word(word_addr(5'd7, 8'h10, 2'd0)));
		// The stored word only comes back if the eviction wrote it to memory.
		add_entry("reload_wb", 1'b0, word_addr(5'd3, 8'h10, 2'd2), '0, 2'd0, 16'hbeef);
		add_entry("st_miss", 1'b1, word_addr(5'd12, 8'h22, 2'd1), 16'h1234, 2'd0, '0);
		for (int w = 0; w < 4; w++) begin
			add_entry($sformatf("sm_w%0d", w), 1'b0, word_addr(5'd12, 8'h22, w[1:0]), '0, 2'd1,
				(w == 1) ? 16'h1234 : mem_word(word_addr(5'd12, 8'h22, w[1:0])));
		end
		add_entry("st_evict", 1'b1, word_addr(5'd20, 8'h22, 2'd3), 16'hc0de, 2'd0, '0);
		add_entry("reload_sm", 1'b0, word_addr(5'd12, 8'h22, 2'd1), '0, 2'd0, 16'h1234);

		// Random traffic on two lines and three tags, checked against the model only.
		for (int k = 0; k < 40; k++) begin
			r = $random(seed);
			t = int'(r[7:0]) % 3;
			tag = (t == 0) ? 5'd2 : ((t == 1) ? 5'd11 : 5'd25);
			idx = r[8] ? 8'hc1 : 8'h40;
			add_entry($sformatf("rand_%0d", k), r[9], word_addr(tag, idx, r[11:10]), r[31:16],
				2'd2, '0);
		end
	endfunction

	task automatic apply_entry(input entry_t e);
		cur_name = e.name;
		cur_hit  = e.hit;
		cur_data = e.rdata;
		address  = e.addr;
		data_sys = e.data;
		ld       = !e.is_st;
		st       = e.is_st;
		@(posedge clk);
		#5;
		ld = 1'b0;
		st = 1'b0;
		while (stall) begin
			@(posedge clk);
			#5;
		end
	endtask

	function automatic void print_counts();
		$display("Error counts: hit %0d, data %0d, protocol %0d", hit_errs, data_errs,
			proto_errs);
	endfunction

	initial begin
		seed     = 32'h7005_5d18;
		clk      = 1'b0;
		rst      = 1'b1;
		ld       = 1'b0;
		st       = 1'b0;
		address  = '0;
		data_sys = '0;
		cur_name = '0;
		cur_hit  = 2'd2;
		cur_data = '0;
		build_table();
		repeat (4) @(posedge clk);
		#5;
		rst = 1'b0;
		foreach (stim[i])
			apply_entry(stim[i]);
		repeat (2) @(posedge clk);
		print_counts();
		if (hit_errs + data_errs + proto_errs == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// A dirty miss takes at most 12 cycles per entry.
	initial begin
		int limit;
		#1;
		limit = stim.size() * 14 + 20;
		repeat (limit) @(posedge clk);
		$display("Run did not finish within %0d cycles, stuck at %0s", limit, cur_name);
		print_counts();
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
cache_pkg.sv
cache_array.sv
main_mem.sv
cache_ctrl.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, and decide on the pass line in sim.log.
cd "$(dirname "$0")" \
	&& verilator --binary --timing --timescale 1ns/1ps --top-module tb_cache \
		-f project.f -o sim_cache \
	&& ./obj_dir/sim_cache | tee sim.log \
	&& grep -qx "No errors" sim.log \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
